//--- hdl/isa_pkg.sv
package isa_pkg;

    localparam int word_w    = 16;               // data path width
    localparam int pc_w      = 12;               // instruction word address width
    localparam int reg_idx_w = 4;
    localparam int imm_w     = 4;                // short signed immediate
    localparam int num_regs  = 1 << reg_idx_w;

    typedef logic [word_w-1:0]    word_t;
    typedef logic [pc_w-1:0]      pc_t;
    typedef logic [reg_idx_w-1:0] reg_idx_t;

    // opcodes in encoding order
    typedef enum logic [3:0] {
        op_add  = 4'd0,
        op_addi = 4'd1,
        op_sub  = 4'd2,
        op_subi = 4'd3,
        op_and  = 4'd4,
        op_or   = 4'd5,
        op_xor  = 4'd6,
        op_nor  = 4'd7,
        op_slt  = 4'd8,
        op_shl  = 4'd9,
        op_slti = 4'd10,
        op_lw   = 4'd11,
        op_sw   = 4'd12,
        op_beq  = 4'd13,
        op_bne  = 4'd14,
        op_j    = 4'd15
    } opcode_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t rs;
        reg_idx_t rt;
        reg_idx_t rd;                            // destination of r-type
    } r_fields_t;

    typedef struct packed {
        opcode_e                  opcode;
        reg_idx_t                 rs;
        reg_idx_t                 rt;            // destination of i-type and lw
        logic signed [imm_w-1:0]  imm;
    } i_fields_t;

    typedef struct packed {
        opcode_e opcode;
        pc_t     target;                         // absolute word address
    } j_fields_t;

    // one 16-bit instruction word seen as r, i or j format
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
        j_fields_t j;
    } instr_t;

endpackage

//--- hdl/ctrl_pkg.sv
package ctrl_pkg;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_and = 4'd2,
        alu_or  = 4'd3,
        alu_xor = 4'd4,
        alu_nor = 4'd5,
        alu_slt = 4'd6,                          // signed less than
        alu_shl = 4'd7                           // shift left by one
    } alu_op_e;

    typedef enum logic [1:0] {
        mem_none  = 2'd0,
        mem_load  = 2'd1,
        mem_store = 2'd2
    } mem_op_e;

    typedef struct packed {
        logic    reg_dst;                        // write rd rather than rt
        logic    jump;
        mem_op_e mem_op;
        logic    mem_to_reg;                     // write back load data
        alu_op_e alu_op;
        logic    alu_src;                        // immediate rather than rt
        logic    reg_write;
        logic    beq;
        logic    bne;
    } ctrl_t;

    // does nothing: no write, no memory access, no pc redirect
    localparam ctrl_t ctrl_nop = '{
        reg_dst: 1'b0, jump: 1'b0, mem_op: mem_none, mem_to_reg: 1'b0,
        alu_op: alu_add, alu_src: 1'b0, reg_write: 1'b0, beq: 1'b0, bne: 1'b0
    };

endpackage

//--- hdl/control_unit.sv
`timescale 1ns/1ns

module control_unit (
    input  logic             clk,
    input  isa_pkg::instr_t  instr,
    output ctrl_pkg::ctrl_t  ctrl
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    always_comb begin
        ctrl = ctrl_nop;                         // fields not set below stay inactive
        case (instr.r.opcode)
            op_add, op_sub, op_and, op_or, op_xor, op_nor, op_slt: begin
                ctrl.reg_dst   = 1'b1;           // r-type writes the third register
                ctrl.reg_write = 1'b1;
                case (instr.r.opcode)
                    op_sub:  ctrl.alu_op = alu_sub;
                    op_and:  ctrl.alu_op = alu_and;
                    op_or:   ctrl.alu_op = alu_or;
                    op_xor:  ctrl.alu_op = alu_xor;
                    op_nor:  ctrl.alu_op = alu_nor;
                    op_slt:  ctrl.alu_op = alu_slt;
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_addi: begin
                ctrl.alu_src   = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            op_subi: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_sub;
                ctrl.reg_write = 1'b1;
            end
            op_slti: begin
                ctrl.alu_src   = 1'b1;
                ctrl.alu_op    = alu_slt;
                ctrl.reg_write = 1'b1;
            end
            op_shl: begin
                ctrl.alu_op    = alu_shl;        // result goes to rt
                ctrl.reg_write = 1'b1;
            end
            op_lw: begin
                ctrl.mem_op     = mem_load;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;          // address is rs + imm
                ctrl.reg_write  = 1'b1;
            end
            op_sw: begin
                ctrl.mem_op  = mem_store;
                ctrl.alu_src = 1'b1;
            end
            op_beq: begin
                ctrl.alu_op = alu_sub;
                ctrl.beq    = 1'b1;
            end
            op_bne: begin
                ctrl.alu_op = alu_sub;
                ctrl.bne    = 1'b1;
            end
            op_j: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl = ctrl_nop;
            end
        endcase
    end

    // pc redirect sources must never compete
    a_one_redirect: assert property (@(posedge clk) $onehot0({ctrl.jump, ctrl.beq, ctrl.bne}))
        else $error("control_unit: more than one of jump/beq/bne set");

endmodule

//--- hdl/program_counter.sv
`timescale 1ns/1ns

module program_counter (
    input  logic             clk,
    input  logic             rst,
    input  isa_pkg::instr_t  instr,
    input  ctrl_pkg::ctrl_t  ctrl,
    input  logic             take_branch,
    output isa_pkg::pc_t     pc
);
    import isa_pkg::*;

    pc_t pc_inc;                                 // fall-through address
    pc_t br_offset;
    pc_t next_pc;

    assign pc_inc    = pc + pc_t'(1);
    assign br_offset = {{(pc_w-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};

    always_comb begin
        if (ctrl.jump) begin
            next_pc = instr.j.target;
        end else if (take_branch) begin
            next_pc = pc_inc + br_offset;        // relative to pc+1
        end else begin
            next_pc = pc_inc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= '0;
        end else begin
            pc <= next_pc;
        end
    end

    // fetch restarts at word 0 once reset is applied
    a_pc_reset: assert property (@(posedge clk) rst |=> pc == '0)
        else $error("program_counter: pc not zero after reset");

endmodule

//--- hdl/register_file.sv
`timescale 1ns/1ns

module register_file (
    input  logic             clk,
    input  logic             rst,
    input  isa_pkg::instr_t  instr,
    input  ctrl_pkg::ctrl_t  ctrl,
    input  isa_pkg::word_t   result,
    input  isa_pkg::word_t   mem_rdata,
    output isa_pkg::word_t   rs_data,
    output isa_pkg::word_t   rt_data
);
    import isa_pkg::*;

    word_t    regs [num_regs];
    reg_idx_t wr_idx;
    word_t    wr_data;

    // write-back select
    assign wr_idx  = ctrl.reg_dst ? instr.r.rd : instr.i.rt;
    assign wr_data = ctrl.mem_to_reg ? mem_rdata : result;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.reg_write && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;             // r0 is never written
        end
    end

    // asynchronous read ports
    assign rs_data = regs[instr.r.rs];
    assign rt_data = regs[instr.r.rt];

    // r0 stays zero even after an instruction targeted it
    a_r0_zero: assert property (@(posedge clk) disable iff (rst) regs[0] == '0)
        else $error("register_file: r0 holds a nonzero value");

endmodule

//--- hdl/alu_stage.sv
`timescale 1ns/1ns

module alu_stage (
    input  isa_pkg::instr_t  instr,
    input  ctrl_pkg::ctrl_t  ctrl,
    input  isa_pkg::word_t   rs_data,
    input  isa_pkg::word_t   rt_data,
    output isa_pkg::word_t   result,
    output logic             take_branch
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    word_t imm_ext;
    word_t op_b;
    logic  is_less;                              // signed rs < op_b

    assign imm_ext = {{(word_w-imm_w){instr.i.imm[imm_w-1]}}, instr.i.imm};
    assign op_b    = ctrl.alu_src ? imm_ext : rt_data;
    assign is_less = $signed(rs_data) < $signed(op_b);

    always_comb begin
        case (ctrl.alu_op)
            alu_add: begin
                result = rs_data + op_b;
            end
            alu_sub: begin
                result = rs_data - op_b;
            end
            alu_and: begin
                result = rs_data & op_b;
            end
            alu_or: begin
                result = rs_data | op_b;
            end
            alu_xor: begin
                result = rs_data ^ op_b;
            end
            alu_nor: begin
                result = ~(rs_data | op_b);
            end
            alu_slt: begin
                result = {{(word_w-1){1'b0}}, is_less};
            end
            alu_shl: begin
                result = {rs_data[word_w-2:0], 1'b0};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // branches always compare the two registers, never the immediate
    assign take_branch = (ctrl.beq && rs_data == rt_data) ||
                         (ctrl.bne && rs_data != rt_data);

endmodule

//--- hdl/cpu_core.sv
`timescale 1ns/1ns

module cpu_core (
    input  logic             clk,
    input  logic             rst,
    output isa_pkg::pc_t     instr_addr,
    input  isa_pkg::instr_t  instr,
    output isa_pkg::word_t   mem_addr,
    output isa_pkg::word_t   mem_wdata,
    output logic             mem_we,
    output logic             mem_re,
    input  isa_pkg::word_t   mem_rdata
);
    import isa_pkg::*;
    import ctrl_pkg::*;

    ctrl_t ctrl;
    word_t rs_data;
    word_t rt_data;
    word_t result;                               // alu output and load/store address
    logic  take_branch;

    control_unit u_control_unit (
        .clk   (clk),
        .instr (instr),
        .ctrl  (ctrl)
    );

    program_counter u_program_counter (
        .clk         (clk),
        .rst         (rst),
        .instr       (instr),
        .ctrl        (ctrl),
        .take_branch (take_branch),
        .pc          (instr_addr)
    );

    register_file u_register_file (
        .clk       (clk),
        .rst       (rst),
        .instr     (instr),
        .ctrl      (ctrl),
        .result    (result),
        .mem_rdata (mem_rdata),
        .rs_data   (rs_data),
        .rt_data   (rt_data)
    );

    alu_stage u_alu_stage (
        .instr       (instr),
        .ctrl        (ctrl),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .result      (result),
        .take_branch (take_branch)
    );

    // memory strobes are levels for the whole cycle, held off during reset
    assign mem_addr  = result;
    assign mem_wdata = rt_data;
    assign mem_we    = (ctrl.mem_op == mem_store) && !rst;
    assign mem_re    = (ctrl.mem_op == mem_load) && !rst;

endmodule

//--- verif/cpu_core_tb.sv
`timescale 1ns/1ns

module cpu_core_tb;
    import isa_pkg::*;

    localparam int rom_depth  = 1 << pc_w;
    localparam int dmem_depth = 256;
    localparam int halt_limit = 100;             // cycles allowed per program

    logic        clk;
    logic        rst;
    pc_t         instr_addr;
    instr_t      instr;
    word_t       mem_addr;
    word_t       mem_wdata;
    logic        mem_we;
    logic        mem_re;
    word_t       mem_rdata;
    instr_t      rom [rom_depth];
    word_t       dmem [dmem_depth];
    pc_t         trace [$];                      // fetch addresses seen after reset
    pc_t         expect_q [$];
    int          errors = 0;
    logic [31:0] rng_state = 32'h76f820bc;

    cpu_core uut (
        .clk        (clk),
        .rst        (rst),
        .instr_addr (instr_addr),
        .instr      (instr),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .mem_rdata  (mem_rdata)
    );

    always #4 clk = ~clk;

    assign instr     = rom[instr_addr];          // combinational fetch
    assign mem_rdata = dmem[mem_addr[7:0]];

    always @(posedge clk) begin
        if (mem_we) begin
            dmem[mem_addr[7:0]] <= mem_wdata;
        end
    end

    // strobes follow the fetched opcode and stay low while reset is held
    always @(negedge clk) begin
        check_flag(mem_we, (instr.i.opcode == op_sw) && !rst, "mem_we");
        check_flag(mem_re, (instr.i.opcode == op_lw) && !rst, "mem_re");
    end

    function automatic word_t rand_word();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state[15:0];
    endfunction

    function automatic word_t fill_word(input int addr);
        return {8'(addr), 8'(addr) ^ 8'ha5};
    endfunction

    function automatic instr_t r_instr(input opcode_e op, input reg_idx_t rs, input reg_idx_t rt,
                                       input reg_idx_t rd);
        instr_t w;
        w.r = '{op, rs, rt, rd};
        return w;
    endfunction

    // operands in assembly order op rt, imm(rs)
    function automatic instr_t i_instr(input opcode_e op, input reg_idx_t rt, input reg_idx_t rs,
                                       input logic signed [3:0] imm);
        instr_t w;
        w.i = '{op, rs, rt, imm};
        return w;
    endfunction

    function automatic instr_t j_instr(input pc_t target);
        instr_t w;
        w.j = '{op_j, target};
        return w;
    endfunction

    function automatic word_t alu_model(input opcode_e op, input word_t a, input word_t b);
        case (op)
            op_add, op_addi: return a + b;
            op_sub, op_subi: return a - b;
            op_and:          return a & b;
            op_or:           return a | b;
            op_xor:          return a ^ b;
            op_nor:          return ~(a | b);
            op_slt, op_slti: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
            op_shl:          return a << 1;
            default:         return '0;
        endcase
    endfunction

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input pc_t got, input pc_t exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic clear_memories();
        for (int i = 0; i < rom_depth; i++) begin
            rom[i] = j_instr(pc_t'(i));          // every unused word is a halt
        end
        for (int i = 0; i < dmem_depth; i++) begin
            dmem[i] = fill_word(i);
        end
    endtask

    task automatic hold_reset();
        @(posedge clk);
        rst <= 1'b1;
        @(posedge clk);
        clear_memories();                        // core is held in reset while memories reload
    endtask

    task automatic run_to_halt(input string name);
        int   cycles;
        logic halted;
        cycles = 0;
        halted = 1'b0;
        trace.delete();
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        while (!halted && cycles < halt_limit) begin
            @(negedge clk);
            trace.push_back(instr_addr);
            halted = instr.j.opcode == op_j && instr.j.target == instr_addr;
            cycles++;
        end
        if (!halted) begin
            $display("test %s hung: no halt within %0d cycles", name, halt_limit);
            errors++;
        end
    endtask

    task automatic check_trace(input string name);
        if (trace.size() != expect_q.size()) begin
            $display("test %s fetched %0d instructions instead of %0d", name, trace.size(),
                     expect_q.size());
            errors++;
        end
        foreach (expect_q[k]) begin
            if (k < trace.size()) begin
                check_addr(trace[k], expect_q[k], $sformatf("%s fetch %0d", name, k));
            end
        end
    endtask

    task automatic test_r_type();
        opcode_e op;
        word_t   a;
        word_t   b;
        for (int k = 0; k < 10; k++) begin
            op = opcode_e'(k);
            if (op == op_addi || op == op_subi) begin
                continue;
            end
            a = rand_word();
            b = rand_word();
            hold_reset();
            dmem[0] = a;
            dmem[1] = b;
            rom[0] = i_instr(op_lw, 4'd1, 4'd0, 4'sd0);
            rom[1] = i_instr(op_lw, 4'd2, 4'd0, 4'sd1);
            rom[2] = r_instr(op, 4'd1, (op == op_shl) ? 4'd3 : 4'd2, 4'd3);  // shl writes rt
            rom[3] = i_instr(op_sw, 4'd3, 4'd0, 4'sd2);
            run_to_halt(op.name());
            check_word(dmem[2], alu_model(op, a, b), {op.name(), " result"});
        end
    endtask

    task automatic test_immediate();
        opcode_e           op;
        logic signed [3:0] imm;
        word_t             a;
        for (int k = 0; k < 3; k++) begin
            op = (k == 0) ? op_addi : (k == 1) ? op_subi : op_slti;
            for (int n = 0; n < 2; n++) begin
                imm = (n == 0) ? -4'sd5 : 4'sd6;
                a = rand_word();
                if (n == 1) begin
                    a = {{12{a[15]}}, a[3:0]};   // small operand near the immediate
                end
                hold_reset();
                dmem[0] = a;
                rom[0] = i_instr(op_lw, 4'd1, 4'd0, 4'sd0);
                rom[1] = i_instr(op, 4'd2, 4'd1, imm);
                rom[2] = i_instr(op_sw, 4'd2, 4'd0, 4'sd1);
                run_to_halt(op.name());
                check_word(dmem[1], alu_model(op, a, {{12{imm[3]}}, imm}),
                           $sformatf("%s with imm %0d", op.name(), imm));
            end
        end
    endtask

    task automatic test_load_store();
        word_t v;
        v = rand_word();
        hold_reset();
        dmem[3] = v;
        rom[0] = i_instr(op_sw, 4'd0, 4'd0, 4'sd4);     // already fetched while reset is held
        rom[1] = i_instr(op_addi, 4'd4, 4'd0, 4'sd5);   // r4 = 5
        rom[2] = i_instr(op_lw, 4'd1, 4'd4, -4'sd2);    // load word 3
        rom[3] = i_instr(op_sw, 4'd1, 4'd4, 4'sd7);     // store to word 12
        run_to_halt("load_store");
        check_word(dmem[4], '0, "stored r0 at 4");
        check_word(dmem[12], v, "stored word at 12");
        check_word(dmem[11], fill_word(11), "untouched word at 11");
        check_word(dmem[3], v, "source word at 3");
    endtask

    task automatic test_branches();
        word_t v;
        v = rand_word();
        hold_reset();
        dmem[0] = v;
        dmem[1] = v;
        dmem[2] = v ^ 16'h0001;
        rom[0]  = i_instr(op_lw, 4'd1, 4'd0, 4'sd0);
        rom[1]  = i_instr(op_lw, 4'd2, 4'd0, 4'sd1);
        rom[2]  = i_instr(op_lw, 4'd3, 4'd0, 4'sd2);
        rom[3]  = i_instr(op_beq, 4'd3, 4'd1, 4'sd3);   // unequal so falls through
        rom[4]  = i_instr(op_beq, 4'd2, 4'd1, 4'sd2);   // forward to 7
        rom[7]  = i_instr(op_bne, 4'd2, 4'd1, -4'sd6);  // backward offset not taken
        rom[8]  = i_instr(op_bne, 4'd3, 4'd1, 4'sd1);   // forward to 10
        rom[10] = i_instr(op_beq, 4'd0, 4'd0, 4'sd2);
        rom[13] = i_instr(op_bne, 4'd3, 4'd1, -4'sd5);  // back to the halt at 9
        expect_q = '{0, 1, 2, 3, 4, 7, 8, 10, 13, 9};
        run_to_halt("branches");
        check_trace("branches");
    endtask

    task automatic test_jump();
        word_t v;
        v = rand_word();
        hold_reset();
        dmem[0] = v;
        rom[0] = i_instr(op_lw, 4'd1, 4'd0, 4'sd0);
        rom[1] = j_instr(12'd4);
        rom[2] = i_instr(op_sw, 4'd1, 4'd0, 4'sd1);     // skipped
        rom[3] = i_instr(op_sw, 4'd1, 4'd0, 4'sd2);     // skipped
        rom[4] = i_instr(op_sw, 4'd1, 4'd0, 4'sd3);
        expect_q = '{0, 1, 4, 5};
        run_to_halt("jump");
        check_trace("jump");
        check_word(dmem[1], fill_word(1), "skipped store to 1");
        check_word(dmem[2], fill_word(2), "skipped store to 2");
        check_word(dmem[3], v, "store at jump target");
    endtask

    task automatic test_r0();
        word_t v;
        v = rand_word() | 16'h0001;
        hold_reset();
        dmem[0] = v;
        rom[0] = i_instr(op_lw, 4'd0, 4'd0, 4'sd0);
        rom[1] = i_instr(op_addi, 4'd0, 4'd0, 4'sd5);
        rom[2] = i_instr(op_sw, 4'd0, 4'd0, 4'sd1);
        run_to_halt("r0");
        check_word(dmem[1], '0, "stored r0");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        clear_memories();
        test_r_type();
        test_immediate();
        test_load_store();
        test_branches();
        test_jump();
        test_r0();
        $display("simulation finished with %0d errors", errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- files.f
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/control_unit.sv
hdl/program_counter.sv
hdl/register_file.sv
hdl/alu_stage.sv
hdl/cpu_core.sv
verif/cpu_core_tb.sv

//--- Bender.yml
package:
  name: cpu_core

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/ctrl_pkg.sv
      - hdl/control_unit.sv
      - hdl/program_counter.sv
      - hdl/register_file.sv
      - hdl/alu_stage.sv
      - hdl/cpu_core.sv
  - target: test
    files:
      - verif/cpu_core_tb.sv
